//--- design/icache_pkg.sv
package icache_pkg;

    //////////////////////////////
    // Fixed widths
    //////////////////////////////
    localparam int ADDR_W = 32;                 // Byte address
    localparam int WORD_W = 32;                 // One instruction

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef addr_t             l2_addr_t;       // Word and byte bits always zero

    localparam addr_t RESET_PC = '0;            // First fetch after reset

    //////////////////////////////
    // Processor side
    //////////////////////////////
    typedef struct packed {
        logic  taken;
        addr_t target;
    } branch_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t instr;
    } fetch_out_t;

    //////////////////////////////
    // Way read and refill write
    //////////////////////////////
    // Returned one cycle after rd_index/rd_word
    typedef struct packed {
        logic  tag_valid;
        addr_t tag;                             // Low TAG_W bits only
        word_t word;
    } way_rd_t;

    // Broadcast to both ways, receivers slice the low bits
    typedef struct packed {
        logic  way_sel;
        logic  line_we;
        logic  tag_we;
        addr_t index;
        addr_t word_sel;
        word_t data;
        addr_t tag;
    } refill_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        REQUEST,                                // Block address waiting on L2
        FILL,                                   // Beats arriving
        COMMIT,                                 // Tag write and victim toggle
        REPLAY                                  // PC reloads the missed address
    } refill_state_t;

endpackage

//--- design/fetch_pipeline.sv
`timescale 1ns/1ps

module fetch_pipeline #(
    parameter int INDEX_BITS = 6,
    parameter int WORD_BITS  = 3
) (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   proc_ready,      // Freezes everything when low
    input  icache_pkg::branch_t    branch,
    input  logic                   cache_ready,     // Low during a refill
    input  logic                   replay,          // Refill done, reload missed PC
    input  icache_pkg::way_rd_t    way0_rd,
    input  icache_pkg::way_rd_t    way1_rd,
    output logic [INDEX_BITS-1:0]  rd_index,
    output logic [WORD_BITS-1:0]   rd_word,
    output logic                   miss,            // One-cycle miss pulse
    output icache_pkg::addr_t      miss_pc,
    output icache_pkg::fetch_out_t fetch_out
);

    // Address field positions
    localparam int WORD_LSB  = 2;
    localparam int INDEX_LSB = WORD_LSB + WORD_BITS;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_BITS;
    localparam int TAG_W     = icache_pkg::ADDR_W - TAG_LSB;

    icache_pkg::addr_t pc;                  // Stage 0, memory read address
    icache_pkg::addr_t pc_d1;               // Stage 1, memory data returning
    icache_pkg::addr_t pc_d2;               // Stage 2, compare result held
    logic              v0;
    logic              v1;
    logic              v2;

    logic              match0;              // Registered, valid-qualified
    logic              match1;
    icache_pkg::word_t word0_q;
    icache_pkg::word_t word1_q;

    logic              hit;
    logic              take_branch;
    logic              stage_en;            // Shift the delay stages

    // Tag compare for one way
    function automatic logic tag_match(input icache_pkg::way_rd_t rd,
                                       input icache_pkg::addr_t   addr);
        return rd.tag_valid && (rd.tag[TAG_W-1:0] == addr[TAG_LSB +: TAG_W]);
    endfunction

    //////////////////////////////
    // Hit, miss and branch
    //////////////////////////////
    assign rd_index = pc[INDEX_LSB +: INDEX_BITS];
    assign rd_word  = pc[WORD_LSB +: WORD_BITS];

    assign hit         = v2 && (match0 || match1);
    assign take_branch = branch.taken && cache_ready;   // Ignored during refill
    assign miss        = v2 && !hit && !take_branch;    // Branch discards stage 2
    assign miss_pc     = pc_d2;
    assign stage_en    = cache_ready && !miss;          // Hold stages on miss

    //////////////////////////////
    // PC select and valids
    //////////////////////////////
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= icache_pkg::RESET_PC;
            v0        <= 1'b1;
            v1        <= 1'b0;
            v2        <= 1'b0;
            fetch_out <= '0;
        end else if (proc_ready) begin
            if (replay) begin
                pc <= pc_d2;                    // Missed address is still in stage 2
                v0 <= 1'b1;
            end else if (take_branch) begin
                pc <= branch.target;
                v0 <= 1'b1;
                v1 <= 1'b0;                     // Drop older fetches
                v2 <= 1'b0;
            end else if (miss) begin
                // Flush, PC stays put until replay
                v0 <= 1'b0;
                v1 <= 1'b0;
                v2 <= 1'b0;
            end else if (cache_ready) begin
                pc <= pc + icache_pkg::addr_t'(4);  // Sequential
                v1 <= v0;
                v2 <= v1;
            end

            // Output register, only moves while not refilling
            if (cache_ready) begin
                fetch_out.valid <= hit && !take_branch;
                if (hit) begin
                    fetch_out.pc    <= pc_d2;
                    fetch_out.instr <= match0 ? word0_q : word1_q;  // Way select
                end
            end
        end
    end

    //////////////////////////////
    // Delay stages and compare
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (proc_ready && stage_en) begin
            pc_d1   <= pc;
            pc_d2   <= pc_d1;
            match0  <= tag_match(way0_rd, pc_d1);   // Ways read pc_d1 last edge
            match1  <= tag_match(way1_rd, pc_d1);
            word0_q <= way0_rd.word;
            word1_q <= way1_rd.word;
        end
    end

endmodule

//--- design/way_store.sv
`timescale 1ns/1ps

module way_store #(
    parameter int INDEX_BITS = 6,
    parameter int WORD_BITS  = 3,
    parameter bit WAY_ID     = 1'b0             // Matched against wr.way_sel
) (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   proc_ready,
    input  logic [INDEX_BITS-1:0]  rd_index,
    input  logic [WORD_BITS-1:0]   rd_word,
    input  icache_pkg::refill_wr_t wr,
    output icache_pkg::way_rd_t    rd
);

    localparam int TAG_W = icache_pkg::ADDR_W - INDEX_BITS - WORD_BITS - 2;
    localparam int LINES = 1 << INDEX_BITS;
    localparam int WORDS = 1 << (INDEX_BITS + WORD_BITS);

    // Storage
    logic [TAG_W-1:0]      tag_mem [LINES];
    icache_pkg::word_t     line_mem [WORDS];    // One word per entry
    logic [LINES-1:0]      valid_bits;          // Flops, cleared by reset

    // Registered read data
    logic                  valid_q;
    logic [TAG_W-1:0]      tag_q;
    icache_pkg::word_t     word_q;

    logic                  sel;
    logic [INDEX_BITS-1:0] wr_index;
    logic [WORD_BITS-1:0]  wr_word;

    assign sel      = (wr.way_sel == WAY_ID);
    assign wr_index = wr.index[INDEX_BITS-1:0];
    assign wr_word  = wr.word_sel[WORD_BITS-1:0];

    //////////////////////////////
    // Tag and line memories
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (proc_ready) begin
            if (sel && wr.line_we)
                line_mem[{wr_index, wr_word}] <= wr.data;
            if (sel && wr.tag_we)
                tag_mem[wr_index] <= wr.tag[TAG_W-1:0];
            tag_q  <= tag_mem[rd_index];
            word_q <= line_mem[{rd_index, rd_word}];
        end
    end

    // Valid bit set along with the tag
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            valid_q    <= 1'b0;
        end else if (proc_ready) begin
            if (sel && wr.tag_we)
                valid_bits[wr_index] <= 1'b1;
            valid_q <= valid_bits[rd_index];
        end
    end

    assign rd.tag_valid = valid_q;
    assign rd.tag       = icache_pkg::addr_t'(tag_q);   // Zero extended
    assign rd.word      = word_q;

endmodule

//--- design/refill_control.sv
`timescale 1ns/1ps

module refill_control #(
    parameter int INDEX_BITS = 6,
    parameter int WORD_BITS  = 3
) (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   proc_ready,
    input  logic                   miss,            // From the compare stage
    input  icache_pkg::addr_t      miss_pc,
    output logic                   cache_ready,
    output logic                   replay,
    output icache_pkg::refill_wr_t wr,              // To both ways

    // L2 address channel
    output logic                   l2_addr_valid,
    output icache_pkg::l2_addr_t   l2_addr,
    input  logic                   l2_addr_ready,

    // L2 data channel, one word per beat
    input  logic                   l2_data_valid,
    input  icache_pkg::word_t      l2_data,
    output logic                   l2_data_ready
);

    localparam int OFFSET_W = WORD_BITS + 2;            // Word and byte bits
    localparam int TAG_LSB  = OFFSET_W + INDEX_BITS;
    localparam int TAG_W    = icache_pkg::ADDR_W - TAG_LSB;
    localparam int LINES    = 1 << INDEX_BITS;

    icache_pkg::refill_state_t state;
    logic [WORD_BITS-1:0]      beat;                     // Word of the next beat
    logic                      victim_way;               // Latched at miss
    logic [LINES-1:0]          victim_bits;              // One per set

    logic [INDEX_BITS-1:0]     miss_index;
    logic [INDEX_BITS-1:0]     fill_index;
    logic                      beat_fire;
    logic                      last_beat;

    assign miss_index = miss_pc[OFFSET_W +: INDEX_BITS];
    assign fill_index = l2_addr[OFFSET_W +: INDEX_BITS];

    //////////////////////////////
    // Status and handshake
    //////////////////////////////
    assign cache_ready   = (state == icache_pkg::IDLE);
    assign replay        = (state == icache_pkg::REPLAY);
    assign l2_data_ready = (state == icache_pkg::FILL);
    assign beat_fire     = l2_data_valid && l2_data_ready;
    assign last_beat     = (beat == '1);

    // Beats go straight into the victim line
    always_comb begin
        wr.way_sel  = victim_way;
        wr.line_we  = beat_fire;
        wr.tag_we   = (state == icache_pkg::COMMIT);
        wr.index    = icache_pkg::addr_t'(fill_index);
        wr.word_sel = icache_pkg::addr_t'(beat);
        wr.data     = l2_data;
        wr.tag      = icache_pkg::addr_t'(l2_addr[TAG_LSB +: TAG_W]);
    end

    //////////////////////////////
    // Miss FSM
    //////////////////////////////
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state         <= icache_pkg::IDLE;
            l2_addr_valid <= 1'b0;
            l2_addr       <= '0;
            beat          <= '0;
            victim_way    <= 1'b0;
            victim_bits   <= '0;
        end else if (proc_ready) begin
            case (state)
                icache_pkg::IDLE: begin
                    if (miss) begin
                        // Block address, offset bits cleared
                        l2_addr       <= {miss_pc[icache_pkg::ADDR_W-1:OFFSET_W],
                                          {OFFSET_W{1'b0}}};
                        victim_way    <= victim_bits[miss_index];
                        l2_addr_valid <= 1'b1;
                        state         <= icache_pkg::REQUEST;
                    end
                end
                icache_pkg::REQUEST: begin
                    if (l2_addr_ready) begin         // Address accepted
                        l2_addr_valid <= 1'b0;
                        beat          <= '0;
                        state         <= icache_pkg::FILL;
                    end
                end
                icache_pkg::FILL: begin
                    if (beat_fire) begin
                        beat <= beat + 1'b1;
                        if (last_beat)
                            state <= icache_pkg::COMMIT;
                    end
                end
                icache_pkg::COMMIT: begin
                    // Other way is the victim next time
                    victim_bits[fill_index] <= ~victim_bits[fill_index];
                    state                   <= icache_pkg::REPLAY;
                end
                icache_pkg::REPLAY: begin
                    state <= icache_pkg::IDLE;      // PC reloads on this edge
                end
                default: begin
                    state <= icache_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int INDEX_BITS = 6,               // 2^INDEX_BITS lines per way
    parameter int WORD_BITS  = 3                // 2^WORD_BITS words per block
) (
    input  logic                   CLK,
    input  logic                   rst_n,

    // Processor side
    input  logic                   proc_ready,  // Global enable
    input  icache_pkg::branch_t    branch,
    output icache_pkg::fetch_out_t fetch_out,
    output logic                   cache_ready,

    // L2 address channel
    output logic                   l2_addr_valid,
    output icache_pkg::l2_addr_t   l2_addr,
    input  logic                   l2_addr_ready,

    // L2 data channel
    input  logic                   l2_data_valid,
    input  icache_pkg::word_t      l2_data,
    output logic                   l2_data_ready
);

    logic [INDEX_BITS-1:0]  rd_index;           // Shared read address
    logic [WORD_BITS-1:0]   rd_word;
    icache_pkg::way_rd_t    way0_rd;
    icache_pkg::way_rd_t    way1_rd;
    icache_pkg::refill_wr_t wr;                 // Refill write broadcast
    logic                   miss;
    icache_pkg::addr_t      miss_pc;
    logic                   replay;

    //////////////////////////////
    // Fetch pipeline
    //////////////////////////////
    fetch_pipeline #(
        .INDEX_BITS (INDEX_BITS),
        .WORD_BITS  (WORD_BITS)
    ) i_fetch_pipeline (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .proc_ready  (proc_ready),
        .branch      (branch),
        .cache_ready (cache_ready),
        .replay      (replay),
        .way0_rd     (way0_rd),
        .way1_rd     (way1_rd),
        .rd_index    (rd_index),
        .rd_word     (rd_word),
        .miss        (miss),
        .miss_pc     (miss_pc),
        .fetch_out   (fetch_out)
    );

    //////////////////////////////
    // Two ways
    //////////////////////////////
    way_store #(
        .INDEX_BITS (INDEX_BITS),
        .WORD_BITS  (WORD_BITS),
        .WAY_ID     (1'b0)
    ) i_way0 (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .proc_ready (proc_ready),
        .rd_index   (rd_index),
        .rd_word    (rd_word),
        .wr         (wr),
        .rd         (way0_rd)
    );

    way_store #(
        .INDEX_BITS (INDEX_BITS),
        .WORD_BITS  (WORD_BITS),
        .WAY_ID     (1'b1)
    ) i_way1 (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .proc_ready (proc_ready),
        .rd_index   (rd_index),
        .rd_word    (rd_word),
        .wr         (wr),
        .rd         (way1_rd)
    );

    //////////////////////////////
    // Miss handling and L2 refill
    //////////////////////////////
    refill_control #(
        .INDEX_BITS (INDEX_BITS),
        .WORD_BITS  (WORD_BITS)
    ) i_refill_control (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .proc_ready    (proc_ready),
        .miss          (miss),
        .miss_pc       (miss_pc),
        .cache_ready   (cache_ready),
        .replay        (replay),
        .wr            (wr),
        .l2_addr_valid (l2_addr_valid),
        .l2_addr       (l2_addr),
        .l2_addr_ready (l2_addr_ready),
        .l2_data_valid (l2_data_valid),
        .l2_data       (l2_data),
        .l2_data_ready (l2_data_ready)
    );

endmodule

//--- tests/icache_asserts.sv
`timescale 1ns/1ps

module icache_asserts #(
    parameter int WORD_BITS = 3
) (
    input logic                 CLK,
    input logic                 rst_n,
    input logic                 proc_ready,
    input logic                 miss,
    input logic                 replay,
    input logic                 cache_ready,
    input logic                 l2_addr_valid,
    input icache_pkg::l2_addr_t l2_addr,
    input logic                 l2_addr_ready,
    input logic                 l2_data_valid,
    input logic                 l2_data_ready
);

    localparam int BEATS = 1 << WORD_BITS;

    int unsigned fail_count = 0;            // Read by the testbench at the end
    int unsigned beats;                     // Beats since the last address
    logic        addr_fire;
    logic        beat_fire;

    assign addr_fire = l2_addr_valid && l2_addr_ready && proc_ready;
    assign beat_fire = l2_data_valid && l2_data_ready && proc_ready;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n)
            beats <= 0;
        else if (addr_fire)
            beats <= 0;                     // New burst
        else if (beat_fire)
            beats <= beats + 1;
    end

    //////////////////////////////
    // L2 protocol
    //////////////////////////////
    addr_aligned: assert property (@(posedge CLK) disable iff (!rst_n)
        l2_addr_valid |-> (l2_addr[WORD_BITS+1:0] == '0))
        else begin
            $error("L2 address has word or byte bits set");
            fail_count++;
        end

    addr_held: assert property (@(posedge CLK) disable iff (!rst_n)
        l2_addr_valid && !(l2_addr_ready && proc_ready) |=> l2_addr_valid && $stable(l2_addr))
        else begin
            $error("L2 address dropped or changed before acceptance");
            fail_count++;
        end

    // No more beats wanted once the block is complete
    beat_limit: assert property (@(posedge CLK) disable iff (!rst_n)
        l2_data_ready |-> (beats < BEATS))
        else begin
            $error("Data ready after the whole block arrived");
            fail_count++;
        end

    beats_at_replay: assert property (@(posedge CLK) disable iff (!rst_n)
        replay |-> (beats == BEATS))
        else begin
            $error("Refill ended with a wrong beat count");
            fail_count++;
        end

    no_data_before_addr: assert property (@(posedge CLK) disable iff (!rst_n)
        l2_data_ready |-> !l2_addr_valid)
        else begin
            $error("Data ready while the address is still pending");
            fail_count++;
        end

    //////////////////////////////
    // Refill control
    //////////////////////////////
    miss_drops_ready: assert property (@(posedge CLK) disable iff (!rst_n)
        miss && proc_ready |=> !cache_ready)
        else begin
            $error("cache_ready still high after a miss");
            fail_count++;
        end

    low_until_replay: assert property (@(posedge CLK) disable iff (!rst_n)
        !cache_ready && !(replay && proc_ready) |=> !cache_ready)
        else begin
            $error("cache_ready rose before replay");
            fail_count++;
        end

    replay_restores: assert property (@(posedge CLK) disable iff (!rst_n)
        replay && proc_ready |=> cache_ready)
        else begin
            $error("cache_ready stayed low after replay");
            fail_count++;
        end

    falls_only_on_miss: assert property (@(posedge CLK) disable iff (!rst_n)
        cache_ready && !(miss && proc_ready) |=> cache_ready)
        else begin
            $error("cache_ready fell without a miss");
            fail_count++;
        end

endmodule

//--- tests/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int INDEX_BITS    = 6;
    localparam int WORD_BITS     = 3;
    localparam int BEATS         = 1 << WORD_BITS;
    localparam int TAG_LSB       = 2 + WORD_BITS + INDEX_BITS;
    localparam int CLK_PERIOD    = 4;
    localparam int TOTAL_FETCHES = 64 + 96 + 64 + 96 + 400;   // Sum over all tests
    localparam int L2_LATENCY    = 4 * (BEATS + 1);            // Slow L2, whole burst
    localparam int WATCHDOG_NS   = TOTAL_FETCHES * 20 * L2_LATENCY * CLK_PERIOD;

    typedef enum int {QUIET, SEQUENTIAL, BRANCHY, STALLY, CONFLICT, RANDOM_MIX} mode_t;

    logic                   CLK = 1'b0;
    logic                   rst_n;
    logic                   proc_ready;
    icache_pkg::branch_t    branch;
    icache_pkg::fetch_out_t fetch_out;
    logic                   cache_ready;
    logic                   l2_addr_valid;
    icache_pkg::l2_addr_t   l2_addr;
    logic                   l2_addr_ready;
    logic                   l2_data_valid;
    icache_pkg::word_t      l2_data;
    logic                   l2_data_ready;

    mode_t             mode = QUIET;
    logic [31:0]       seed = 32'h1bea;
    logic [31:0]       r1;
    logic [31:0]       r2;
    logic              slow;                        // L2 inserts delays
    icache_pkg::addr_t resp_addr = '0;              // Block being returned
    int                resp_word = 0;
    logic              resp_active = 1'b0;
    icache_pkg::addr_t exp_pc = icache_pkg::RESET_PC;
    int                fetch_count = 0;
    int                branch_count = 0;
    int                refill_count = 0;
    int                errors = 0;

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    icache_top #(
        .INDEX_BITS (INDEX_BITS),
        .WORD_BITS  (WORD_BITS)
    ) i_icache_top (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .proc_ready    (proc_ready),
        .branch        (branch),
        .fetch_out     (fetch_out),
        .cache_ready   (cache_ready),
        .l2_addr_valid (l2_addr_valid),
        .l2_addr       (l2_addr),
        .l2_addr_ready (l2_addr_ready),
        .l2_data_valid (l2_data_valid),
        .l2_data       (l2_data),
        .l2_data_ready (l2_data_ready)
    );

    bind icache_top icache_asserts #(.WORD_BITS(WORD_BITS)) i_icache_asserts (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .proc_ready    (proc_ready),
        .miss          (miss),
        .replay        (replay),
        .cache_ready   (cache_ready),
        .l2_addr_valid (l2_addr_valid),
        .l2_addr       (l2_addr),
        .l2_addr_ready (l2_addr_ready),
        .l2_data_valid (l2_data_valid),
        .l2_data_ready (l2_data_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Memory contents seen through L2
    function automatic icache_pkg::word_t model_instr(input icache_pkg::addr_t a);
        return a ^ 32'hc0de_0000;
    endfunction

    // Four tags on the same two sets
    function automatic icache_pkg::addr_t conflict_target(input logic [31:0] r);
        icache_pkg::addr_t t;
        t = icache_pkg::addr_t'(r[13:12]) << (TAG_LSB + 1);
        t = t | icache_pkg::addr_t'({r[5:2], 2'b00});
        return t;
    endfunction

    function automatic int total_errors();
        return errors + int'(i_icache_top.i_icache_asserts.fail_count);
    endfunction

    //////////////////////////////
    // Stimulus and L2 responder
    //////////////////////////////
    always @(posedge CLK) begin
        if (rst_n) begin
            if (l2_addr_valid && l2_addr_ready && proc_ready) begin
                resp_addr    = l2_addr;             // Burst starts at word 0
                resp_word    = 0;
                resp_active  = 1'b1;
                refill_count <= refill_count + 1;
            end else if (l2_data_valid && l2_data_ready && proc_ready) begin
                resp_word = resp_word + 1;
                if (resp_word == BEATS)
                    resp_active = 1'b0;
            end
            seed = xorshift32(seed);
            r1   = seed;
            seed = xorshift32(seed);
            r2   = seed;
            case (mode)
                STALLY:     proc_ready <= (r1[1:0] != 2'd0);
                RANDOM_MIX: proc_ready <= (r1[6:0] >= 7'd13);   // About 10% low
                default:    proc_ready <= 1'b1;
            endcase
            case (mode)
                BRANCHY:    branch.taken <= (r1[10:8] == 3'd0);
                CONFLICT:   branch.taken <= (r1[9:8] == 2'd0);
                RANDOM_MIX: branch.taken <= (r1[11:8] == 4'd0);
                default:    branch.taken <= 1'b0;
            endcase
            if (mode == CONFLICT)
                branch.target <= conflict_target(r2);
            else
                branch.target <= icache_pkg::addr_t'({r2[11:2], 2'b00});  // 4 KiB window
            slow = (mode == STALLY) || (mode == RANDOM_MIX);
            l2_addr_ready <= slow ? (r1[17:16] == 2'd0) : 1'b1;
            l2_data_valid <= resp_active && (slow ? (r1[19:18] != 2'd0) : 1'b1);
            l2_data       <= model_instr(resp_addr + icache_pkg::addr_t'(resp_word * 4));
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    always @(posedge CLK) begin
        if (rst_n && proc_ready) begin
            if (fetch_out.valid) begin
                assert (fetch_out.instr == model_instr(fetch_out.pc)) else begin
                    $display("Fail @ %0t ns: pc %h gave instr %h, expected %h", $time,
                             fetch_out.pc, fetch_out.instr, model_instr(fetch_out.pc));
                    errors++;
                end
                assert (fetch_out.pc == exp_pc) else begin
                    $display("Fail @ %0t ns: pc %h delivered, expected %h", $time,
                             fetch_out.pc, exp_pc);
                    errors++;
                end
                exp_pc = fetch_out.pc + 32'd4;      // Sequential by default
                fetch_count <= fetch_count + 1;
            end
            if (branch.taken && cache_ready) begin
                exp_pc = branch.target;             // Accepted branch redirects
                branch_count <= branch_count + 1;
            end
        end
        if (rst_n) begin
            assert (cache_ready || !fetch_out.valid) else begin
                $display("Fail @ %0t ns: fetch_out valid during a refill", $time);
                errors++;
            end
        end
    end

    hold_on_stall: assert property (@(posedge CLK) disable iff (!rst_n)
        !proc_ready |=> $stable(fetch_out) && $stable(l2_addr_valid) && $stable(l2_addr))
        else begin
            $display("Fail @ %0t ns: outputs moved while proc_ready was low", $time);
            errors++;
        end

    task automatic run_test(input string name, input mode_t m, input int fetches);
        int start_fetch;
        int start_err;
        @(negedge CLK);
        start_fetch = fetch_count;
        start_err   = total_errors();
        @(posedge CLK);
        mode <= m;
        while (fetch_count - start_fetch < fetches)
            @(negedge CLK);
        $display("%-12s ends at %0t ns: %0d fetches, %0d errors", name, $time,
                 fetch_count - start_fetch, total_errors() - start_err);
    endtask

    initial begin
        rst_n         = 1'b0;
        proc_ready    = 1'b0;
        branch        = '0;
        l2_addr_ready = 1'b0;
        l2_data_valid = 1'b0;
        l2_data       = '0;
        repeat (10) @(posedge CLK);
        assert (!fetch_out.valid && !l2_addr_valid && !l2_data_ready && cache_ready) else begin
            $display("Fail @ %0t ns: outputs not in their reset state", $time);
            errors++;
        end
        rst_n <= 1'b1;
        run_test("sequential", SEQUENTIAL, 64);
        run_test("branch", BRANCHY, 96);
        run_test("stall", STALLY, 64);
        run_test("conflict", CONFLICT, 96);
        run_test("random mix", RANDOM_MIX, 400);
        @(posedge CLK);
        mode <= QUIET;
        $display("5 tests, %0d fetches, %0d branches, %0d refills, %0d errors",
                 fetch_count, branch_count, refill_count, total_errors());
        if (total_errors() == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Guards against a stalled fetch stream
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns, the fetch stream stopped advancing", $time);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- icache.f
design/icache_pkg.sv
design/fetch_pipeline.sv
design/way_store.sv
design/refill_control.sv
design/icache_top.sv
tests/icache_asserts.sv
tests/icache_tb.sv
